/* game2048Pkg.sv */
`default_nettype none

package game2048Pkg;

    // one-hot tile, bit n means 2^(n+1)
    localparam int tileWidth = 11;
    localparam int gridSize = 4;

    typedef logic [tileWidth-1:0] tileT;
    typedef tileT [gridSize-1:0] lineT;
    typedef tileT [gridSize-1:0][gridSize-1:0] boardT;
    typedef logic [3:0] cellIndexT;
    typedef logic [11:0] colorT;
    typedef logic [9:0] coordT;

    typedef struct packed {
        coordT hCount;
        coordT vCount;
    } pixelPosT;

    // priority order, up first
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } moveReqT;

    typedef enum logic [2:0] {
        stInit,
        stWait,
        stUp,
        stDown,
        stLeft,
        stRight,
        stWin,
        stLose
    } gameStateT;

    localparam tileT tileEmpty = '0;
    localparam tileT tileTwo = tileT'(1);
    localparam tileT tileWin = tileT'(1 << (tileWidth - 1));

    // key strip along the top
    localparam int keyTop = 20;
    localparam int keyBottom = 60;
    localparam int keyLeft = 130;
    localparam int keyPitch = 50;
    localparam int keySize = 40;
    localparam int keyCount = 11;

    // playing field
    localparam int boardTop = 180;
    localparam int boardLeft = 380;
    localparam int cellPitch = 45;
    localparam int cellSize = 40;

    localparam colorT colorBlank = 12'b0110_0110_0110;
    localparam colorT colorOff = 12'b0000_0000_0000;
    localparam colorT bgPlay = 12'b1111_1111_1111;
    localparam colorT bgWin = 12'b0000_1000_0000;
    localparam colorT bgLose = 12'b1000_0000_0000;

    // entry 0 is the 2 tile, entry 10 the 2048 tile
    localparam colorT paletteTable [tileWidth] = '{
        12'b1110_1101_1100,
        12'b1100_1001_1000,
        12'b1101_1001_0101,
        12'b1111_1000_0100,
        12'b1111_0110_0101,
        12'b1111_0011_0011,
        12'b1110_1011_0100,
        12'b1111_1011_0000,
        12'b1000_1011_0101,
        12'b0100_1010_1101,
        12'b0001_0101_1101
    };

    function automatic colorT tileColor(tileT tile);
        colorT color;
        color = colorBlank;
        for (int n = 0; n < tileWidth; n++) begin
            if (tile == tileT'(1 << n)) begin
                color = paletteTable[n];
            end
        end
        return color;
    endfunction

endpackage

`default_nettype wire

/* lineSlider.sv */
`default_nettype none
`timescale 1ns/100ps

module lineSlider (
    input  game2048Pkg::lineT lineIn,
    output game2048Pkg::lineT lineOut
);
    import game2048Pkg::*;

    lineT work;

    // pass order: bring cell p forward one step at a time toward cell 0
    always_comb begin
        work = lineIn;
        for (int p = 1; p < gridSize; p++) begin
            for (int k = p; k >= 1; k--) begin
                if (work[k-1] == tileEmpty) begin
                    work[k-1] = work[k];
                    work[k] = tileEmpty;
                end else if (work[k-1] == work[k]) begin
                    // equal tiles merge, value doubles
                    work[k-1] = work[k-1] << 1;
                    work[k] = tileEmpty;
                end
            end
        end
        lineOut = work;
    end

    // merged tiles must stay one-hot
    always_comb begin
        for (int c = 0; c < gridSize; c++) begin
            if (!$isunknown(lineIn)) begin
                assert ($onehot0(lineOut[c]))
                    else $error("lineSlider: cell %0d not one-hot: %b", c, lineOut[c]);
            end
        end
    end

endmodule

`default_nettype wire

/* boardShifter.sv */
`default_nettype none
`timescale 1ns/100ps

module boardShifter (
    input  game2048Pkg::boardT     board,
    input  game2048Pkg::gameStateT gameState,
    output game2048Pkg::boardT     shifted
);
    import game2048Pkg::*;

    lineT [gridSize-1:0] linesIn;
    lineT [gridSize-1:0] linesOut;

    // gather lines so that element 0 sits on the edge we move toward
    always_comb begin
        for (int i = 0; i < gridSize; i++) begin
            for (int k = 0; k < gridSize; k++) begin
                unique case (gameState)
                    stUp:    linesIn[i][k] = board[k][i];
                    stDown:  linesIn[i][k] = board[gridSize-1-k][i];
                    stLeft:  linesIn[i][k] = board[i][k];
                    stRight: linesIn[i][k] = board[i][gridSize-1-k];
                    default: linesIn[i][k] = board[i][k];
                endcase
            end
        end
    end

    for (genvar i = 0; i < gridSize; i++) begin : genSlider
        lineSlider slider (
            .lineIn  (linesIn[i]),
            .lineOut (linesOut[i])
        );
    end

    // scatter results back along the same paths
    always_comb begin
        shifted = board;
        for (int i = 0; i < gridSize; i++) begin
            for (int k = 0; k < gridSize; k++) begin
                unique case (gameState)
                    stUp:    shifted[k][i] = linesOut[i][k];
                    stDown:  shifted[gridSize-1-k][i] = linesOut[i][k];
                    stLeft:  shifted[i][k] = linesOut[i][k];
                    stRight: shifted[i][gridSize-1-k] = linesOut[i][k];
                    default: shifted[i][k] = board[i][k];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* boardStatus.sv */
`default_nettype none
`timescale 1ns/100ps

module boardStatus (
    input  game2048Pkg::boardT     board,
    output logic                   hasEmpty,
    output logic                   hasWinTile,
    output game2048Pkg::cellIndexT firstEmpty
);
    import game2048Pkg::*;

    // row-major scan, lowest empty index wins
    always_comb begin
        hasEmpty = 1'b0;
        hasWinTile = 1'b0;
        firstEmpty = '0;
        for (int r = 0; r < gridSize; r++) begin
            for (int c = 0; c < gridSize; c++) begin
                if (board[r][c] == tileEmpty) begin
                    if (!hasEmpty) begin
                        firstEmpty = cellIndexT'(r * gridSize + c);
                    end
                    hasEmpty = 1'b1;
                end
                if (board[r][c] == tileWin) begin
                    hasWinTile = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* gameControl.sv */
`default_nettype none
`timescale 1ns/100ps

module gameControl (
    input  logic                   Clk,
    input  logic                   Reset,
    input  game2048Pkg::moveReqT   move,
    input  game2048Pkg::boardT     shifted,
    input  logic                   hasEmpty,
    input  logic                   hasWinTile,
    input  game2048Pkg::cellIndexT firstEmpty,
    output game2048Pkg::boardT     board,
    output game2048Pkg::gameStateT gameState
);
    import game2048Pkg::*;

    gameStateT nextState;
    logic placePending;
    logic [1:0] placeRow;
    logic [1:0] placeCol;

    // cell index is row * 4 + col
    assign placeRow = firstEmpty[3:2];
    assign placeCol = firstEmpty[1:0];

    // status comes from the board before this cycle's placement
    always_comb begin
        nextState = gameState;
        unique case (gameState)
            stInit: nextState = stWait;
            stWait: begin
                if (hasWinTile) begin
                    nextState = stWin;
                end else if (!hasEmpty) begin
                    nextState = stLose;
                end else if (move.up) begin
                    nextState = stUp;
                end else if (move.down) begin
                    nextState = stDown;
                end else if (move.left) begin
                    nextState = stLeft;
                end else if (move.right) begin
                    nextState = stRight;
                end
            end
            stUp, stDown, stLeft, stRight: nextState = stWait;
            // win and lose hold until reset
            default: nextState = gameState;
        endcase
    end

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            gameState <= stInit;
            board <= '0;
            placePending <= 1'b0;
        end else begin
            gameState <= nextState;
            unique case (gameState)
                stInit: begin
                    board <= '0;
                    board[0][0] <= tileTwo;
                    placePending <= 1'b1;
                end
                stWait: begin
                    // new 2 goes into the first free cell
                    if (placePending) begin
                        if (hasEmpty) begin
                            board[placeRow][placeCol] <= tileTwo;
                        end
                        placePending <= 1'b0;
                    end
                end
                stUp, stDown, stLeft, stRight: begin
                    board <= shifted;
                    placePending <= 1'b1;
                end
                default: begin
                    board <= board;
                end
            endcase
        end
    end

    // a move lasts exactly one cycle
    assert property (@(posedge Clk) disable iff (Reset)
        gameState inside {stUp, stDown, stLeft, stRight} |=> gameState == stWait)
        else $error("gameControl: move state not followed by stWait");

    // end states are sticky
    assert property (@(posedge Clk) disable iff (Reset)
        gameState inside {stWin, stLose} |=> gameState == $past(gameState))
        else $error("gameControl: left an end state without reset");

endmodule

`default_nettype wire

/* pixelRenderer.sv */
`default_nettype none
`timescale 1ns/100ps

module pixelRenderer (
    input  game2048Pkg::pixelPosT  pixel,
    input  logic                   bright,
    input  game2048Pkg::boardT     board,
    input  game2048Pkg::gameStateT gameState,
    output game2048Pkg::colorT     rgb
);
    import game2048Pkg::*;

    logic inKeyRow;
    logic keyHit;
    logic [3:0] keyIdx;
    logic rowHit;
    logic colHit;
    logic [1:0] rowIdx;
    logic [1:0] colIdx;
    colorT background;

    assign inKeyRow = (pixel.vCount >= coordT'(keyTop)) && (pixel.vCount <= coordT'(keyBottom));

    // key squares never overlap, so at most one matches
    always_comb begin
        keyHit = 1'b0;
        keyIdx = '0;
        for (int n = 0; n < keyCount; n++) begin
            if ((pixel.hCount >= coordT'(keyLeft + n * keyPitch)) &&
                (pixel.hCount <= coordT'(keyLeft + n * keyPitch + keySize))) begin
                keyHit = 1'b1;
                keyIdx = 4'(n);
            end
        end
    end

    // board row and column found separately
    always_comb begin
        rowHit = 1'b0;
        colHit = 1'b0;
        rowIdx = '0;
        colIdx = '0;
        for (int i = 0; i < gridSize; i++) begin
            if ((pixel.vCount >= coordT'(boardTop + i * cellPitch)) &&
                (pixel.vCount <= coordT'(boardTop + i * cellPitch + cellSize))) begin
                rowHit = 1'b1;
                rowIdx = 2'(i);
            end
            if ((pixel.hCount >= coordT'(boardLeft + i * cellPitch)) &&
                (pixel.hCount <= coordT'(boardLeft + i * cellPitch + cellSize))) begin
                colHit = 1'b1;
                colIdx = 2'(i);
            end
        end
    end

    always_comb begin
        unique case (gameState)
            stWin:   background = bgWin;
            stLose:  background = bgLose;
            default: background = bgPlay;
        endcase
    end

    always_comb begin
        if (!bright) begin
            rgb = colorOff;
        end else if (inKeyRow && keyHit) begin
            rgb = paletteTable[keyIdx];
        end else if (rowHit && colHit) begin
            // empty cells come back as colorBlank
            rgb = tileColor(board[rowIdx][colIdx]);
        end else begin
            rgb = background;
        end
    end

endmodule

`default_nettype wire

/* game2048Top.sv */
`default_nettype none
`timescale 1ns/100ps

module game2048Top (
    input  logic                   Clk,
    input  logic                   Reset,
    input  game2048Pkg::moveReqT   move,
    input  game2048Pkg::pixelPosT  pixel,
    input  logic                   bright,
    output game2048Pkg::colorT     rgb,
    output game2048Pkg::gameStateT gameState
);
    import game2048Pkg::*;

    boardT board;
    boardT shifted;
    logic hasEmpty;
    logic hasWinTile;
    cellIndexT firstEmpty;

    gameControl control (
        .Clk        (Clk),
        .Reset      (Reset),
        .move       (move),
        .shifted    (shifted),
        .hasEmpty   (hasEmpty),
        .hasWinTile (hasWinTile),
        .firstEmpty (firstEmpty),
        .board      (board),
        .gameState  (gameState)
    );

    // direction comes straight from the move state
    boardShifter shifter (
        .board     (board),
        .gameState (gameState),
        .shifted   (shifted)
    );

    boardStatus status (
        .board      (board),
        .hasEmpty   (hasEmpty),
        .hasWinTile (hasWinTile),
        .firstEmpty (firstEmpty)
    );

    pixelRenderer renderer (
        .pixel     (pixel),
        .bright    (bright),
        .board     (board),
        .gameState (gameState),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

/* tbGame2048.sv */
`default_nettype none
`timescale 1ns/100ps

module tbGame2048;
    import game2048Pkg::*;

    logic Clk;
    logic Reset;
    moveReqT move;
    pixelPosT pixel;
    logic bright;
    colorT rgb;
    gameStateT gameState;

    int errors = 0;
    int testErrors = 0;

    // reference model with cells in row-major order
    gameStateT mState;
    tileT mb [16];
    logic mPending;
    tileT readTiles [16];

    // directed table of moves packed up/down/left/right with the first move in the top nibble
    logic [15:0] seqMoves [6] = '{16'h2000, 16'h1000, 16'h4000, 16'h8200, 16'h8220, 16'h2112};
    int seqLen [6] = '{1, 1, 1, 2, 3, 4};
    // expected exponents, one nibble per cell in row-major order
    logic [63:0] seqExpect [6] = '{
        64'h2100_0000_0000_0000,
        64'h1002_0000_0000_0000,
        64'h1000_0000_0000_1100,
        64'h2110_0000_0000_0000,
        64'h3100_0000_0000_0000,
        64'h3110_0000_0000_0000
    };

    game2048Top dut (
        .Clk       (Clk),
        .Reset     (Reset),
        .move      (move),
        .pixel     (pixel),
        .bright    (bright),
        .rgb       (rgb),
        .gameState (gameState)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    initial begin
        #2ms;
        $display("simulation timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic int lineCell(gameStateT dir, int i, int k);
        case (dir)
            stUp:    return k * 4 + i;
            stDown:  return (3 - k) * 4 + i;
            stLeft:  return i * 4 + k;
            default: return i * 4 + (3 - k);
        endcase
    endfunction

    // one clock edge of the model following the FSM rules
    task automatic modelEdge(moveReqT m);
        tileT ln [4];
        logic anyEmpty;
        logic anyWin;
        int first;
        anyEmpty = 1'b0;
        anyWin = 1'b0;
        first = 0;
        for (int i = 15; i >= 0; i--) begin
            if (mb[i] == tileEmpty) begin
                anyEmpty = 1'b1;
                first = i;
            end
            if (mb[i] == tileWin) anyWin = 1'b1;
        end
        case (mState)
            stInit: begin
                for (int i = 0; i < 16; i++) mb[i] = tileEmpty;
                mb[0] = tileTwo;
                mPending = 1'b1;
                mState = stWait;
            end
            stWait: begin
                if (mPending && anyEmpty) mb[first] = tileTwo;
                mPending = 1'b0;
                if (anyWin) mState = stWin;
                else if (!anyEmpty) mState = stLose;
                else if (m.up) mState = stUp;
                else if (m.down) mState = stDown;
                else if (m.left) mState = stLeft;
                else if (m.right) mState = stRight;
            end
            stUp, stDown, stLeft, stRight: begin
                for (int i = 0; i < 4; i++) begin
                    for (int k = 0; k < 4; k++) ln[k] = mb[lineCell(mState, i, k)];
                    // each cell walks forward and merges with an equal neighbour
                    for (int p = 1; p < 4; p++) begin
                        for (int k = p; k >= 1; k--) begin
                            if (ln[k-1] == tileEmpty) begin
                                ln[k-1] = ln[k];
                                ln[k] = tileEmpty;
                            end else if (ln[k-1] == ln[k]) begin
                                ln[k-1] = ln[k-1] << 1;
                                ln[k] = tileEmpty;
                            end
                        end
                    end
                    for (int k = 0; k < 4; k++) mb[lineCell(mState, i, k)] = ln[k];
                end
                mPending = 1'b1;
                mState = stWait;
            end
            default: mState = mState;
        endcase
    endtask

    task automatic valueError(string name, logic [31:0] expected, logic [31:0] actual);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    // drive, advance one edge, compare state
    task automatic stepCycle(moveReqT m);
        move = m;
        modelEdge(m);
        @(posedge Clk);
        #2;
        if (gameState !== mState) begin
            valueError("gameState", 32'(mState), 32'(gameState));
        end
    endtask

    task automatic doReset();
        Reset = 1'b1;
        move = '0;
        repeat (2) @(posedge Clk);
        #2;
        Reset = 1'b0;
        mState = stInit;
        mPending = 1'b0;
        for (int i = 0; i < 16; i++) mb[i] = tileEmpty;
        if (gameState !== stInit) valueError("gameState", 32'(stInit), 32'(gameState));
    endtask

    task automatic waitForState(gameStateT target);
        int n;
        n = 0;
        while (gameState !== target && n < 40) begin
            stepCycle('0);
            n++;
        end
        if (gameState !== target) begin
            $display("waited too long for state %s at %0t", target.name(), $time);
            errors++;
        end
    endtask

    task automatic applyMove(moveReqT m);
        waitForState(stWait);
        stepCycle(m);
        stepCycle('0);
        stepCycle('0);
    endtask

    function automatic tileT rgbToTile(colorT c);
        tileT t;
        t = (c == colorBlank) ? tileEmpty : '1;
        for (int n = 0; n < tileWidth; n++) begin
            if (c == tileColor(tileT'(1 << n))) t = tileT'(1 << n);
        end
        return t;
    endfunction

    task automatic readBoard();
        bright = 1'b1;
        for (int i = 0; i < 16; i++) begin
            pixel.hCount = coordT'(boardLeft + (i % 4) * cellPitch + cellSize / 2);
            pixel.vCount = coordT'(boardTop + (i / 4) * cellPitch + cellSize / 2);
            #0.5;
            readTiles[i] = rgbToTile(rgb);
        end
    endtask

    function automatic tileT tableTile(logic [63:0] v, int i);
        logic [3:0] e;
        e = v[63 - 4 * i -: 4];
        return (e == 0) ? tileEmpty : tileT'(1 << (e - 1));
    endfunction

    task automatic checkPixel(int h, int v, colorT expected);
        pixel.hCount = coordT'(h);
        pixel.vCount = coordT'(v);
        #0.5;
        if (rgb !== expected) valueError("rgb", 32'(expected), 32'(rgb));
    endtask

    function automatic colorT modelBackground();
        if (mState == stWin) return bgWin;
        if (mState == stLose) return bgLose;
        return bgPlay;
    endfunction

    task automatic reportTest(string name);
        $display("test %s: %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    initial begin
        int moveCount;
        moveReqT m;
        Reset = 1'b1;
        move = '0;
        pixel = '0;
        bright = 1'b0;
        void'($urandom(32'h97ab_4c17));

        // after reset the FSM goes init then wait and shows two 2s on the top row
        doReset();
        stepCycle('0);
        stepCycle('0);
        readBoard();
        for (int i = 0; i < 16; i++) begin
            if (readTiles[i] !== tableTile(64'h1100_0000_0000_0000, i)) begin
                valueError($sformatf("cell %0d", i), 32'(tableTile(64'h1100_0000_0000_0000, i)),
                    32'(readTiles[i]));
            end
        end
        reportTest("reset");

        for (int t = 0; t < $size(seqLen); t++) begin
            doReset();
            for (int s = 0; s < seqLen[t]; s++) begin
                applyMove(moveReqT'(seqMoves[t][15 - 4 * s -: 4]));
            end
            readBoard();
            for (int i = 0; i < 16; i++) begin
                if (readTiles[i] !== tableTile(seqExpect[t], i)) begin
                    valueError($sformatf("cell %0d", i), 32'(tableTile(seqExpect[t], i)),
                        32'(readTiles[i]));
                end
            end
            reportTest($sformatf("table entry %0d", t));
        end

        // with several bits at once the highest priority wins
        doReset();
        for (int p = 0; p < 4; p++) begin
            waitForState(stWait);
            stepCycle(moveReqT'(4'b1111 >> p));
            if (gameState !== gameStateT'(stUp + p)) begin
                valueError("gameState", 32'(stUp + p), 32'(gameState));
            end
            stepCycle('0);
            stepCycle('0);
        end
        reportTest("priority");

        doReset();
        moveCount = 0;
        while (moveCount < 400 && mState != stWin && mState != stLose) begin
            m = moveReqT'(4'b0001 << ($urandom % 4));
            applyMove(m);
            readBoard();
            for (int i = 0; i < 16; i++) begin
                if (readTiles[i] !== mb[i]) begin
                    valueError($sformatf("cell %0d", i), 32'(mb[i]), 32'(readTiles[i]));
                end
            end
            moveCount++;
        end
        // one more edge lets a full board reach stLose
        stepCycle('0);
        bright = 1'b1;
        checkPixel(5, 100, modelBackground());
        reportTest($sformatf("random run, %0d moves, ended in %s", moveCount, mState.name()));

        doReset();
        stepCycle('0);
        bright = 1'b0;
        checkPixel(keyLeft + 5, keyTop + 5, colorOff);
        bright = 1'b1;
        for (int n = 0; n < keyCount; n++) begin
            checkPixel(keyLeft + n * keyPitch, keyTop, paletteTable[n]);
            checkPixel(keyLeft + n * keyPitch + keySize, keyBottom, paletteTable[n]);
            checkPixel(keyLeft + n * keyPitch + keySize / 2, (keyTop + keyBottom) / 2,
                paletteTable[n]);
        end
        checkPixel(keyLeft - 1, keyTop, bgPlay);
        checkPixel(boardLeft - 1, boardTop, bgPlay);
        reportTest("rendering");

        $display("checks done: %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* game2048Top.f */
game2048Pkg.sv
lineSlider.sv
boardShifter.sv
boardStatus.sv
gameControl.sv
pixelRenderer.sv
game2048Top.sv
tbGame2048.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f game2048Top.f --top-module tbGame2048

simOutput=$(./obj_dir/VtbGame2048)
echo "$simOutput"

if ! grep -q "TEST RESULT: PASS" <<< "$simOutput"; then
    exit 1
fi
